//--- design/i2c_page_pkg.sv
package i2c_page_pkg;

    // ------------------------------
    // shared widths
    // ------------------------------
    localparam int ADDR_W = 16;                 // page in the high byte, offset in the low byte
    localparam int STEP_W = 3;                  // byte step count of one request

    typedef logic [7:0] byte_t;

    // ------------------------------
    // engine register map
    // ------------------------------
    typedef enum logic [2:0] {
        REG_PRER_LO = 3'd0,                     // prescaler low byte
        REG_PRER_HI = 3'd1,                     // prescaler high byte
        REG_CTR     = 3'd2,                     // control
        REG_TXR     = 3'd3,                     // transmit, receive on the read side
        REG_CR      = 3'd4                      // command, status on the read side
    } reg_addr_t;

    localparam reg_addr_t REG_SR = REG_CR;      // status read shares the command address

    // command register opcodes
    typedef enum logic [7:0] {
        CMD_WRITE       = 8'h10,                // write byte
        CMD_WRITE_STOP  = 8'h50,                // write byte then stop
        CMD_START_WRITE = 8'h90                 // start then write byte
    } cr_cmd_t;

    localparam byte_t CTR_ENABLE        = 8'h80;    // core enable bit
    localparam byte_t PAGE_SELECT_INDEX = 8'h01;    // slave register holding the page
    localparam int    SR_TIP_BIT        = 1;        // transfer in progress

    // ------------------------------
    // sequencer states
    // ------------------------------
    typedef enum logic [3:0] {
        S_INIT_PREH,
        S_INIT_PREL,
        S_INIT_CTR,
        S_IDLE,
        S_LOAD_TX,
        S_ISSUE_CMD,
        S_SETTLE,
        S_POLL,
        S_DONE
    } seq_state_t;

endpackage

//--- design/page_cache.sv
`timescale 1ns/1ns

module page_cache (
    input  logic                clock,
    input  logic                reset,
    input  logic                capture_i,
    input  i2c_page_pkg::byte_t page_i,
    output logic                same_page_o
);
    import i2c_page_pkg::*;

    byte_t page_q;                              // last page sent to the slave
    logic  valid_q;                             // no page known after reset
    logic  same_page_q;

    // hit flag and valid bit
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            valid_q     <= 1'b0;
            same_page_q <= 1'b0;
        end
        else if (capture_i)
        begin
            same_page_q <= valid_q && (page_q == page_i);   // compare against the old page
            valid_q     <= 1'b1;
        end
    end

    // stored page
    always_ff @(posedge clock)
    begin
        if (capture_i)
        begin
            page_q <= page_i;
        end
    end

    assign same_page_o = same_page_q;

endmodule

//--- design/settle_timer.sv
`timescale 1ns/1ns

module settle_timer #(
    parameter int SETTLE_CYCLES = 3
) (
    input  logic clock,
    input  logic reset,
    input  logic start_i,
    output logic expired_o
);

    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    logic [CNT_W-1:0] count_q;

    // loaded on start, runs down to zero and parks there
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            count_q <= '0;
        end
        else if (start_i)
        begin
            count_q <= CNT_W'(SETTLE_CYCLES);
        end
        else if (count_q != '0)
        begin
            count_q <= count_q - 1'b1;
        end
    end

    // the last count is the cycle SETTLE_CYCLES after start
    assign expired_o = (count_q == CNT_W'(1));

endmodule

//--- design/reg_bus_master.sv
`timescale 1ns/1ns

module reg_bus_master (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    access_i,
    input  logic                    we_i,
    input  i2c_page_pkg::reg_addr_t adr_i,
    input  i2c_page_pkg::byte_t     wdata_i,
    input  logic                    reg_ack_i,
    input  i2c_page_pkg::byte_t     reg_rdata_i,
    output logic                    done_o,
    output i2c_page_pkg::byte_t     rdata_o,
    output logic                    reg_req_o,
    output logic                    reg_we_o,
    output i2c_page_pkg::reg_addr_t reg_adr_o,
    output i2c_page_pkg::byte_t     reg_wdata_o
);
    import i2c_page_pkg::*;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_WAIT_ACK,
        BUS_WAIT_RELEASE
    } bus_state_t;

    bus_state_t bus_state_q;
    byte_t      rdata_q;

    // ------------------------------
    // handshake phases
    // ------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            bus_state_q <= BUS_IDLE;
            reg_req_o   <= 1'b0;
        end
        else
        begin
            case (bus_state_q)
                BUS_IDLE:
                begin
                    if (access_i)
                    begin
                        reg_req_o   <= 1'b1;
                        bus_state_q <= BUS_WAIT_ACK;
                    end
                end
                BUS_WAIT_ACK:
                begin
                    if (reg_ack_i)
                    begin
                        reg_req_o   <= 1'b0;        // phase 3, release the request
                        bus_state_q <= BUS_WAIT_RELEASE;
                    end
                end
                default:
                begin
                    if (!reg_ack_i)
                    begin
                        bus_state_q <= BUS_IDLE;
                    end
                end
            endcase
        end
    end

    // bus fields held for the whole access
    always_ff @(posedge clock)
    begin
        if (bus_state_q == BUS_IDLE && access_i)
        begin
            reg_we_o    <= we_i;
            reg_adr_o   <= adr_i;
            reg_wdata_o <= wdata_i;
        end
        if (bus_state_q == BUS_WAIT_ACK && reg_ack_i)
        begin
            rdata_q <= reg_rdata_i;                 // read data valid with ack high
        end
    end

    assign rdata_o = rdata_q;
    assign done_o  = (bus_state_q == BUS_WAIT_RELEASE) && !reg_ack_i;

endmodule

//--- design/write_sequencer.sv
`timescale 1ns/1ns

module write_sequencer #(
    parameter logic [15:0] PRESCALE   = 16'h003F,
    parameter logic [6:0]  SLAVE_ADDR = 7'h10
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            start_i,
    input  logic [i2c_page_pkg::ADDR_W-1:0] address_i,
    input  i2c_page_pkg::byte_t             data_i,
    input  logic                            same_page_i,
    input  logic                            access_done_i,
    input  i2c_page_pkg::byte_t             rdata_i,
    input  logic                            expired_i,
    output logic                            ready_o,
    output logic                            done_o,
    output logic                            capture_o,
    output logic                            access_o,
    output logic                            we_o,
    output i2c_page_pkg::reg_addr_t         adr_o,
    output i2c_page_pkg::byte_t             wdata_o,
    output logic                            settle_start_o
);
    import i2c_page_pkg::*;

    localparam logic [STEP_W-1:0] PAGE_HIT_STEP = 3'd3;    // second transfer starts here
    localparam logic [STEP_W-1:0] LAST_STEP     = 3'd5;

    seq_state_t        state_q;
    logic [STEP_W-1:0] step_q;
    logic              issued_q;                // access of this state already sent
    logic              step_sel_q;              // page hit result pending
    byte_t             page_q;
    byte_t             offset_q;
    byte_t             data_q;
    byte_t             tx_byte;
    cr_cmd_t           tx_cmd;
    logic              access_state;

    assign ready_o        = (state_q == S_IDLE);
    assign done_o         = (state_q == S_DONE);
    assign capture_o      = ready_o && start_i;
    assign settle_start_o = (state_q == S_ISSUE_CMD) && access_done_i;
    assign access_o       = access_state && !issued_q && !step_sel_q;

    // ------------------------------
    // byte step decode
    // ------------------------------
    always_comb
    begin
        case (step_q)
            3'd0:    begin tx_byte = {SLAVE_ADDR, 1'b0}; tx_cmd = CMD_START_WRITE; end
            3'd1:    begin tx_byte = PAGE_SELECT_INDEX;  tx_cmd = CMD_WRITE;       end
            3'd2:    begin tx_byte = page_q;             tx_cmd = CMD_WRITE_STOP;  end
            3'd3:    begin tx_byte = {SLAVE_ADDR, 1'b0}; tx_cmd = CMD_START_WRITE; end
            3'd4:    begin tx_byte = offset_q;           tx_cmd = CMD_WRITE;       end
            default: begin tx_byte = data_q;             tx_cmd = CMD_WRITE_STOP;  end
        endcase
    end

    // register access of each state
    always_comb
    begin
        access_state = 1'b1;
        we_o         = 1'b1;
        adr_o        = REG_TXR;
        wdata_o      = tx_byte;
        case (state_q)
            S_INIT_PREH: begin adr_o = REG_PRER_HI; wdata_o = PRESCALE[15:8]; end
            S_INIT_PREL: begin adr_o = REG_PRER_LO; wdata_o = PRESCALE[7:0];  end
            S_INIT_CTR:  begin adr_o = REG_CTR;     wdata_o = CTR_ENABLE;     end
            S_LOAD_TX:   adr_o = REG_TXR;
            S_ISSUE_CMD: begin adr_o = REG_CR;      wdata_o = byte_t'(tx_cmd); end
            S_POLL:
            begin
                we_o    = 1'b0;                     // status read
                adr_o   = REG_SR;
                wdata_o = 8'h00;
            end
            default:     access_state = 1'b0;
        endcase
    end

    // ------------------------------
    // state machine
    // ------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state_q    <= S_INIT_PREH;
            step_q     <= '0;
            issued_q   <= 1'b0;
            step_sel_q <= 1'b0;
        end
        else
        begin
            if (access_o)
            begin
                issued_q <= 1'b1;
            end
            if (access_done_i)
            begin
                issued_q <= 1'b0;
            end
            case (state_q)
                S_INIT_PREH: if (access_done_i) state_q <= S_INIT_PREL;
                S_INIT_PREL: if (access_done_i) state_q <= S_INIT_CTR;
                S_INIT_CTR:  if (access_done_i) state_q <= S_IDLE;
                S_IDLE:
                begin
                    if (start_i)
                    begin
                        step_sel_q <= 1'b1;
                        state_q    <= S_LOAD_TX;
                    end
                end
                S_LOAD_TX:
                begin
                    if (step_sel_q)
                    begin
                        step_sel_q <= 1'b0;         // page cache answer is valid now
                        step_q     <= same_page_i ? PAGE_HIT_STEP : '0;
                    end
                    else if (access_done_i)
                    begin
                        state_q <= S_ISSUE_CMD;
                    end
                end
                S_ISSUE_CMD: if (access_done_i) state_q <= S_SETTLE;
                S_SETTLE:    if (expired_i) state_q <= S_POLL;
                S_POLL:
                begin
                    // a busy status simply reissues the read
                    if (access_done_i && !rdata_i[SR_TIP_BIT])
                    begin
                        if (step_q == LAST_STEP)
                        begin
                            state_q <= S_DONE;
                        end
                        else
                        begin
                            step_q  <= step_q + 1'b1;
                            state_q <= S_LOAD_TX;
                        end
                    end
                end
                default:     state_q <= S_IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge clock)
    begin
        if (capture_o)
        begin
            page_q   <= address_i[15:8];
            offset_q <= address_i[7:0];
            data_q   <= data_i;
        end
    end

endmodule

//--- design/i2c_page_writer.sv
`timescale 1ns/1ns

module i2c_page_writer #(
    parameter logic [15:0] PRESCALE      = 16'h003F,
    parameter logic [6:0]  SLAVE_ADDR    = 7'h10,
    parameter int          SETTLE_CYCLES = 3
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            start_i,
    input  logic [i2c_page_pkg::ADDR_W-1:0] address_i,
    input  i2c_page_pkg::byte_t             data_i,
    input  logic                            reg_ack_i,
    input  i2c_page_pkg::byte_t             reg_rdata_i,
    output logic                            ready_o,
    output logic                            done_o,
    output logic                            reg_req_o,
    output logic                            reg_we_o,
    output i2c_page_pkg::reg_addr_t         reg_adr_o,
    output i2c_page_pkg::byte_t             reg_wdata_o
);
    import i2c_page_pkg::*;

    logic      same_page;
    logic      capture;
    logic      access;
    logic      access_done;
    logic      we;
    reg_addr_t adr;
    byte_t     wdata;
    byte_t     rdata;
    logic      settle_start;
    logic      expired;

    // ------------------------------
    // control
    // ------------------------------
    write_sequencer #(
        .PRESCALE   (PRESCALE),
        .SLAVE_ADDR (SLAVE_ADDR)
    ) u_sequencer (
        .clock          (clock),
        .reset          (reset),
        .start_i        (start_i),
        .address_i      (address_i),
        .data_i         (data_i),
        .same_page_i    (same_page),
        .access_done_i  (access_done),
        .rdata_i        (rdata),
        .expired_i      (expired),
        .ready_o        (ready_o),
        .done_o         (done_o),
        .capture_o      (capture),
        .access_o       (access),
        .we_o           (we),
        .adr_o          (adr),
        .wdata_o        (wdata),
        .settle_start_o (settle_start)
    );

    settle_timer #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_settle_timer (
        .clock     (clock),
        .reset     (reset),
        .start_i   (settle_start),
        .expired_o (expired)
    );

    // ------------------------------
    // data path
    // ------------------------------
    reg_bus_master u_bus_master (
        .clock       (clock),
        .reset       (reset),
        .access_i    (access),
        .we_i        (we),
        .adr_i       (adr),
        .wdata_i     (wdata),
        .reg_ack_i   (reg_ack_i),
        .reg_rdata_i (reg_rdata_i),
        .done_o      (access_done),
        .rdata_o     (rdata),
        .reg_req_o   (reg_req_o),
        .reg_we_o    (reg_we_o),
        .reg_adr_o   (reg_adr_o),
        .reg_wdata_o (reg_wdata_o)
    );

    page_cache u_page_cache (
        .clock       (clock),
        .reset       (reset),
        .capture_i   (capture),
        .page_i      (address_i[15:8]),            // page is the high address byte
        .same_page_o (same_page)
    );

endmodule

//--- verification/byte_engine_model.sv
`timescale 1ns/1ns

module byte_engine_model #(
    parameter logic [31:0] ACK_PATTERN = 32'h9C36_E4B1,    // two bits per access, extra ack wait
    parameter int          BUSY_CYCLES = 4
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    req_i,
    input  logic                    we_i,
    input  i2c_page_pkg::reg_addr_t adr_i,
    input  i2c_page_pkg::byte_t     wdata_i,
    output logic                    ack_o,
    output i2c_page_pkg::byte_t     rdata_o,
    output logic                    wr_valid_o,
    output i2c_page_pkg::reg_addr_t wr_adr_o,
    output i2c_page_pkg::byte_t     wr_data_o,
    output logic                    busy_o
);
    import i2c_page_pkg::*;

    logic       ack_q   = 1'b0;
    byte_t      rdata_q = 8'h00;
    logic       pending_q;                      // request seen, ack not yet given
    logic [1:0] wait_q;
    logic [3:0] slot_q;                         // position in the ack pattern
    logic       cmd_seen_q;
    logic [3:0] busy_cnt_q;
    byte_t      status;

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;
    assign busy_o  = (busy_cnt_q != '0);

    always_comb
    begin
        status             = '0;
        status[SR_TIP_BIT] = busy_o;
    end

    // ------------------------------
    // four-phase responder
    // ------------------------------
    always @(posedge clock)
    begin
        if (reset)
        begin
            ack_q      <= 1'b0;
            pending_q  <= 1'b0;
            slot_q     <= '0;
            wr_valid_o <= 1'b0;
            cmd_seen_q <= 1'b0;
        end
        else
        begin
            wr_valid_o <= 1'b0;
            cmd_seen_q <= 1'b0;
            if (req_i && !ack_q && !pending_q)
            begin
                pending_q <= 1'b1;
                wait_q    <= ACK_PATTERN[2 * slot_q +: 2];
                slot_q    <= slot_q + 1'b1;
            end
            else if (pending_q && wait_q != '0)
            begin
                wait_q <= wait_q - 1'b1;
            end
            else if (pending_q)
            begin
                pending_q <= 1'b0;
                ack_q     <= 1'b1;
                rdata_q   <= (adr_i == REG_SR) ? status : 8'h00;
                if (we_i)
                begin
                    wr_valid_o <= 1'b1;         // one entry of the write log
                    wr_adr_o   <= adr_i;
                    wr_data_o  <= wdata_i;
                    cmd_seen_q <= (adr_i == REG_CR);
                end
            end
            else if (ack_q && !req_i)
            begin
                ack_q <= 1'b0;
            end
        end
    end

    // busy bit follows each command write by one cycle
    always @(posedge clock)
    begin
        if (reset)
        begin
            busy_cnt_q <= '0;
        end
        else if (cmd_seen_q)
        begin
            busy_cnt_q <= 4'(BUSY_CYCLES);
        end
        else if (busy_cnt_q != '0)
        begin
            busy_cnt_q <= busy_cnt_q - 1'b1;
        end
    end

endmodule

//--- verification/i2c_page_writer_asserts.sv
`timescale 1ns/1ns

module i2c_page_writer_asserts (
    input logic                    clock,
    input logic                    reset,
    input logic                    reg_req_i,
    input logic                    reg_ack_i,
    input logic                    reg_we_i,
    input i2c_page_pkg::reg_addr_t reg_adr_i,
    input i2c_page_pkg::byte_t     reg_wdata_i
);

    // request held until the slave answers
    a_req_held : assert property (@(posedge clock) disable iff (reset)
        reg_req_i && !reg_ack_i |=> reg_req_i)
        else $error("reg_req_o dropped before reg_ack_i");

    a_fields_stable : assert property (@(posedge clock) disable iff (reset)
        reg_req_i && $past(reg_req_i) |->
            $stable(reg_we_i) && $stable(reg_adr_i) && $stable(reg_wdata_i))
        else $error("register bus fields changed while reg_req_o was high");

    // phase 4 must finish before a new access
    a_no_req_during_ack : assert property (@(posedge clock) disable iff (reset)
        $rose(reg_req_i) |-> !reg_ack_i)
        else $error("reg_req_o rose while reg_ack_i was still high");

endmodule

bind reg_bus_master i2c_page_writer_asserts u_asserts (
    .clock       (clock),
    .reset       (reset),
    .reg_req_i   (reg_req_o),
    .reg_ack_i   (reg_ack_i),
    .reg_we_i    (reg_we_o),
    .reg_adr_i   (reg_adr_o),
    .reg_wdata_i (reg_wdata_o)
);

//--- verification/tb_i2c_page_writer.sv
`timescale 1ns/1ns

module tb_i2c_page_writer;
    import i2c_page_pkg::*;

    localparam logic [15:0] PRESCALE        = 16'h003F;    // DUT defaults
    localparam logic [6:0]  SLAVE_ADDR      = 7'h10;
    localparam int          ENGINE_BUSY     = 12;          // outlasts the settle, first poll sees busy
    localparam int          NUM_RANDOM      = 40;
    localparam int          NUM_REQUESTS    = NUM_RANDOM + 4;
    localparam int          WATCHDOG_CYCLES = 100 + 400 * NUM_REQUESTS;

    logic        clock;
    logic        reset;
    logic        start;
    logic [15:0] address;
    byte_t       data;
    logic        ready;
    logic        done;
    logic        reg_req;
    logic        reg_we;
    reg_addr_t   reg_adr;
    byte_t       reg_wdata;
    logic        reg_ack;
    byte_t       reg_rdata;
    logic        wr_valid;
    reg_addr_t   wr_adr;
    byte_t       wr_data;
    logic        engine_busy;

    logic [10:0] exp_q [$];                     // {register, byte} in bus order
    logic [7:0]  lfsr_q;
    int          accepted;
    int          done_count;
    int          write_count;
    logic        done_q;
    logic        page_known;
    byte_t       last_page;

    i2c_page_writer u_dut (
        .clock       (clock),
        .reset       (reset),
        .start_i     (start),
        .address_i   (address),
        .data_i      (data),
        .reg_ack_i   (reg_ack),
        .reg_rdata_i (reg_rdata),
        .ready_o     (ready),
        .done_o      (done),
        .reg_req_o   (reg_req),
        .reg_we_o    (reg_we),
        .reg_adr_o   (reg_adr),
        .reg_wdata_o (reg_wdata)
    );

    byte_engine_model #(
        .BUSY_CYCLES (ENGINE_BUSY)
    ) u_model (
        .clock      (clock),
        .reset      (reset),
        .req_i      (reg_req),
        .we_i       (reg_we),
        .adr_i      (reg_adr),
        .wdata_i    (reg_wdata),
        .ack_o      (reg_ack),
        .rdata_o    (reg_rdata),
        .wr_valid_o (wr_valid),
        .wr_adr_o   (wr_adr),
        .wr_data_o  (wr_data),
        .busy_o     (engine_busy)
    );

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic abort_run(input string what);
        $display("%0t ns: %s", $time, what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic mismatch_error(input string name, input logic [15:0] got,
                                  input logic [15:0] expected);
        $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, expected);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        logic [7:0] next;
        next = state >> 1;
        if (state[0])
        begin
            next = next ^ 8'hB8;                // x^8 + x^6 + x^5 + x^4 + 1
        end
        return next;
    endfunction

    function automatic logic [15:0] take_bits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value  = {value[14:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return value;
    endfunction

    // expected writes of one request, TXR then CR for each byte
    function automatic void build_expected_writes(input logic [15:0] addr, input byte_t value,
                                                  input logic known, input byte_t prev_page);
        byte_t tx_bytes [6];
        byte_t commands [6];
        int    first;
        tx_bytes = '{{SLAVE_ADDR, 1'b0}, 8'h01, addr[15:8], {SLAVE_ADDR, 1'b0}, addr[7:0], value};
        commands = '{8'h90, 8'h10, 8'h50, 8'h90, 8'h10, 8'h50};
        first    = (known && prev_page == addr[15:8]) ? 3 : 0;   // page hit skips the select
        for (int i = first; i < 6; i++)
        begin
            exp_q.push_back({REG_TXR, tx_bytes[i]});
            exp_q.push_back({REG_CR, commands[i]});
        end
    endfunction

    task automatic send_request(input logic [15:0] addr, input byte_t value,
                                input logic poke_while_busy);
        @(posedge clock);
        #1;
        while (!ready)
        begin
            @(posedge clock);
            #1;
        end
        start   = 1'b1;
        address = addr;
        data    = value;
        build_expected_writes(addr, value, page_known, last_page);
        page_known = 1'b1;
        last_page  = addr[15:8];
        accepted++;
        @(posedge clock);
        #1;
        start = 1'b0;
        if (poke_while_busy)
        begin
            repeat (5) @(posedge clock);
            #1;
            assert (!ready) else abort_run("ready_o was high while a request was still running");
            start   = 1'b1;                     // must be ignored
            address = addr ^ 16'h0155;
            data    = ~value;
            @(posedge clock);
            #1;
            start = 1'b0;
        end
        while (done_count < accepted)
        begin
            @(posedge clock);
        end
        assert (exp_q.size() == 0) else abort_run("request finished with register writes missing");
    endtask

    // ------------------------------
    // clock, compare and watchdog
    // ------------------------------
    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(negedge clock)
    begin : compare_writes
        logic [10:0] exp_pair;
        if (wr_valid)
        begin
            assert (exp_q.size() != 0) else abort_run("the engine got a write that was not expected");
            exp_pair = exp_q.pop_front();
            assert (wr_adr == exp_pair[10:8])
                else mismatch_error("reg_adr_o", 16'(wr_adr), 16'(exp_pair[10:8]));
            assert (wr_data == exp_pair[7:0])
                else mismatch_error("reg_wdata_o", 16'(wr_data), 16'(exp_pair[7:0]));
            assert (wr_adr != REG_TXR || !engine_busy)
                else abort_run("the transmit register was written while the engine was busy");
            write_count++;
        end
        assert (!ready || write_count >= 3) else abort_run("ready_o rose before initialisation");
        assert (!(done_q && done)) else abort_run("done_o stayed high for more than one cycle");
        assert (!done_q || ready) else abort_run("ready_o did not rise the cycle after done_o");
        if (done)
        begin
            done_count++;
        end
        done_q = done;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        abort_run("watchdog expired before all requests were finished");
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial
    begin : stimulus
        logic [15:0] bits;
        byte_t       page;
        byte_t       offset;
        byte_t       value;
        logic [1:0]  gap;
        reset       = 1'b1;
        start       = 1'b0;
        address     = '0;
        data        = '0;
        lfsr_q      = 8'd96;
        accepted    = 0;
        done_count  = 0;
        write_count = 0;
        done_q      = 1'b0;
        page_known  = 1'b0;
        last_page   = '0;
        exp_q.push_back({REG_PRER_HI, PRESCALE[15:8]});
        exp_q.push_back({REG_PRER_LO, PRESCALE[7:0]});
        exp_q.push_back({REG_CTR, 8'h80});
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        while (!ready)
        begin
            @(posedge clock);
            #1;
        end
        assert (exp_q.size() == 0) else abort_run("init writes were missing when ready_o rose");

        send_request(16'h0012, 8'hA5, 1'b0);    // first request on page 0
        send_request(16'h0034, 8'h5A, 1'b0);    // same page
        send_request(16'h0207, 8'h3C, 1'b0);    // new page
        send_request(16'h0240, 8'hC3, 1'b1);    // start pulsed while busy

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            bits   = take_bits(2);
            page   = (bits[1:0] == 2'd3) ? 8'd0 : {6'd0, bits[1:0]};
            bits   = take_bits(8);
            offset = bits[7:0];
            bits   = take_bits(8);
            value  = bits[7:0];
            bits   = take_bits(2);
            gap    = bits[1:0];
            send_request({page, offset}, value, 1'b0);
            repeat (gap) @(posedge clock);
        end

        repeat (20) @(posedge clock);
        if (done_count != accepted)
        begin
            mismatch_error("done_o pulses", 16'(done_count), 16'(accepted));
        end
        else if (exp_q.size() != 0)
        begin
            abort_run("expected register writes never arrived");
        end
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- project.f
design/i2c_page_pkg.sv
design/page_cache.sv
design/settle_timer.sv
design/reg_bus_master.sv
design/write_sequencer.sv
design/i2c_page_writer.sv
verification/byte_engine_model.sv
verification/i2c_page_writer_asserts.sv
verification/tb_i2c_page_writer.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_i2c_page_writer \
    -f project.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
